//--- src/ooo_cfg.svh
// Execution back end configuration
// Widths, depths, lane layout and opcode encodings shared by the design

`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Operand and ROB tag widths
`define OOO_DATA_WIDTH    32
`define OOO_TAG_WIDTH     5

// One reservation station, one functional unit and one CDB lane per lane index
`define OOO_CDB_LANES     3
`define OOO_RS_DEPTH      4

// Scratch memory owned by the load/store unit
`define OOO_MEM_WORDS     16

// Lanes with a load/store unit attached, the rest are integer units
`define OOO_LANE_IS_LSU   3'b100

// Opcode encodings
`define OOO_OPCODE_WIDTH  3
`define OOO_OP_ADD        3'd0
`define OOO_OP_SUB        3'd1
`define OOO_OP_AND        3'd2
`define OOO_OP_XOR        3'd3
`define OOO_OP_LOAD       3'd4
`define OOO_OP_STORE      3'd5

`endif

//--- src/ooo_pkg.sv
// Execution back end types
// Operand, operation and CDB formats plus the CDB snoop function

`include "ooo_cfg.svh"

`default_nettype none

package ooo_pkg;

    typedef logic [`OOO_DATA_WIDTH-1:0] data_t;
    typedef logic [`OOO_TAG_WIDTH-1:0]  tag_t;
    typedef logic [`OOO_CDB_LANES-1:0]  lane_mask_t;

    typedef enum logic [`OOO_OPCODE_WIDTH-1:0] {
        OP_ADD   = `OOO_OP_ADD,
        OP_SUB   = `OOO_OP_SUB,
        OP_AND   = `OOO_OP_AND,
        OP_XOR   = `OOO_OP_XOR,
        OP_LOAD  = `OOO_OP_LOAD,
        OP_STORE = `OOO_OP_STORE
    } opcode_e;

    typedef enum logic {
        FU_IEU = 1'b0,
        FU_LSU = 1'b1
    } fu_type_e;

    typedef struct packed {
        logic  rdy;
        tag_t  tag;
        data_t data;
    } src_opnd_t;

    typedef struct packed {
        opcode_e   opcode;
        tag_t      dst_tag;
        src_opnd_t src0;
        src_opnd_t src1;
    } rs_op_t;

    typedef struct packed {
        logic  en;
        tag_t  tag;
        data_t data;
    } cdb_t;

    // A waiting source picks up the value of any CDB lane that broadcasts its tag
    function automatic src_opnd_t cdb_snoop(src_opnd_t src, cdb_t cdb [0:`OOO_CDB_LANES-1]);
        src_opnd_t res;
        res = src;
        for (int lane = 0; lane < `OOO_CDB_LANES; lane++) begin
            if (!src.rdy && cdb[lane].en && (cdb[lane].tag == src.tag)) begin
                res.rdy  = 1'b1;
                res.data = cdb[lane].data;
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- src/rr_picker.sv
// Round-robin picker
// Grants one requesting lane, starting the search just after the last winner

`include "ooo_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module rr_picker import ooo_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_valid,
    input  logic       i_advance,
    input  lane_mask_t i_requests,
    output lane_mask_t o_grant
);

    localparam int LANES = `OOO_CDB_LANES;
    localparam int PTR_W = $clog2(LANES);

    logic [PTR_W-1:0] last_q;
    logic [PTR_W-1:0] win_idx;
    logic             found;

    // Scan the lanes in rotating order, the last winner comes last
    always_comb begin
        int idx;
        o_grant = '0;
        win_idx = last_q;
        found   = 1'b0;
        for (int k = 1; k <= LANES; k++) begin
            idx = (int'(last_q) + k) % LANES;
            if (!found && i_requests[idx]) begin
                o_grant[idx] = 1'b1;
                win_idx      = PTR_W'(idx);
                found        = 1'b1;
            end
        end
    end

    // Lane 0 has top priority out of reset
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_q <= PTR_W'(LANES - 1);
        end else if (i_valid && i_advance && found) begin
            last_q <= win_idx;
        end
    end

endmodule

`default_nettype wire

//--- src/rs_switch.sv
// Reservation station switch
// Routes each dispatched op to a station of the right FU type, round robin,
// and bypasses source operands from the CDB in the dispatch cycle

`include "ooo_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module rs_switch import ooo_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,

    input  logic       i_dispatch_en,
    input  rs_op_t     i_dispatch_op,

    input  cdb_t       i_cdb [0:`OOO_CDB_LANES-1],

    input  lane_mask_t i_rs_full,
    output lane_mask_t o_rs_reserve_en,
    output rs_op_t     o_rs_op,
    output logic       o_dispatch_stall
);

    localparam lane_mask_t LSU_LANES = `OOO_LANE_IS_LSU;

    fu_type_e   fu_type;
    lane_mask_t rs_supported;
    lane_mask_t rs_granted;
    logic       dispatch_ok;

    // Memory ops need a load/store lane, everything else runs on an integer unit
    always_comb begin
        if ((i_dispatch_op.opcode == OP_LOAD) || (i_dispatch_op.opcode == OP_STORE)) begin
            fu_type = FU_LSU;
        end else begin
            fu_type = FU_IEU;
        end
    end

    assign rs_supported = (fu_type == FU_LSU) ? LSU_LANES : ~LSU_LANES;

    rr_picker u_rr_picker (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (i_dispatch_en),
        .i_advance  (~o_dispatch_stall),
        .i_requests (rs_supported),
        .o_grant    (rs_granted)
    );

    // A full station holds off dispatch until it drains an entry
    assign o_dispatch_stall = i_dispatch_en & (|(rs_granted & i_rs_full));
    assign dispatch_ok      = i_dispatch_en & ~o_dispatch_stall;
    assign o_rs_reserve_en  = dispatch_ok ? rs_granted : '0;

    // Catch a producer that broadcasts in the same cycle as the dispatch,
    // otherwise the station would miss its tag forever
    always_comb begin
        o_rs_op      = i_dispatch_op;
        o_rs_op.src0 = cdb_snoop(i_dispatch_op.src0, i_cdb);
        o_rs_op.src1 = cdb_snoop(i_dispatch_op.src1, i_cdb);
    end

endmodule

`default_nettype wire

//--- src/reservation_station.sv
// Reservation station
// Age-ordered entry queue that snoops the CDB and issues the oldest ready
// entry, or only the head entry when configured for in-order issue

`include "ooo_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; #(
    parameter bit P_IN_ORDER = 1'b0
)(
    input  logic   i_clk,
    input  logic   i_reset,

    input  logic   i_reserve_en,
    input  rs_op_t i_op,

    input  cdb_t   i_cdb [0:`OOO_CDB_LANES-1],

    output logic   o_full,
    output logic   o_issue_en,
    output rs_op_t o_issue_op
);

    localparam int DEPTH = `OOO_RS_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    // Entry 0 is always the oldest, the valid bits form a thermometer code
    rs_op_t           entry_q     [0:DEPTH-1];
    rs_op_t           entry_woken [0:DEPTH-1];
    rs_op_t           entry_n     [0:DEPTH-1];
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] valid_n;
    logic [DEPTH-1:0] ready;

    logic             issue_any;
    logic [IDX_W-1:0] issue_idx;

    assign o_full = &valid_q;

    // Wakeup runs on every entry every cycle
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entry_woken[i]      = entry_q[i];
            entry_woken[i].src0 = cdb_snoop(entry_q[i].src0, i_cdb);
            entry_woken[i].src1 = cdb_snoop(entry_q[i].src1, i_cdb);
            ready[i] = valid_q[i] & entry_q[i].src0.rdy & entry_q[i].src1.rdy;
        end
    end

    // Loads and stores must leave in program order to keep memory consistent
    always_comb begin
        issue_any = 1'b0;
        issue_idx = '0;
        if (P_IN_ORDER) begin
            issue_any = ready[0];
        end else begin
            for (int i = DEPTH - 1; i >= 0; i--) begin
                if (ready[i]) begin
                    issue_any = 1'b1;
                    issue_idx = IDX_W'(i);
                end
            end
        end
    end

    // Close the gap left by the issued entry, then append the new op
    always_comb begin
        logic placed;
        placed = 1'b0;
        for (int i = 0; i < DEPTH - 1; i++) begin
            if (issue_any && (i >= int'(issue_idx))) begin
                entry_n[i] = entry_woken[i+1];
                valid_n[i] = valid_q[i+1];
            end else begin
                entry_n[i] = entry_woken[i];
                valid_n[i] = valid_q[i];
            end
        end
        entry_n[DEPTH-1] = entry_woken[DEPTH-1];
        valid_n[DEPTH-1] = valid_q[DEPTH-1] & ~issue_any;

        if (i_reserve_en) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (!placed && !valid_n[i]) begin
                    entry_n[i] = i_op;
                    valid_n[i] = 1'b1;
                    placed     = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q    <= '0;
            o_issue_en <= 1'b0;
        end else begin
            valid_q    <= valid_n;
            o_issue_en <= issue_any;
        end
    end

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            entry_q[i] <= entry_n[i];
        end
        o_issue_op <= entry_q[issue_idx];
    end

endmodule

`default_nettype wire

//--- src/exec_unit.sv
// Functional unit
// Registered integer ALU or load/store unit with a scratch memory,
// driving one CDB lane a cycle after issue

`include "ooo_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module exec_unit import ooo_pkg::*; #(
    parameter fu_type_e P_FU_TYPE = FU_IEU
)(
    input  logic   i_clk,
    input  logic   i_reset,

    input  logic   i_issue_en,
    input  rs_op_t i_issue_op,

    output cdb_t   o_cdb
);

    data_t result;

    generate
        if (P_FU_TYPE == FU_LSU) begin : g_lsu
            localparam int ADDR_W = $clog2(`OOO_MEM_WORDS);

            data_t             mem_q [0:`OOO_MEM_WORDS-1];
            logic [ADDR_W-1:0] addr;
            logic              is_store;

            // The address comes straight from src0, there is no offset
            assign addr     = i_issue_op.src0.data[ADDR_W-1:0];
            assign is_store = (i_issue_op.opcode == OP_STORE);

            always_ff @(posedge i_clk) begin
                if (i_issue_en && is_store) begin
                    mem_q[addr] <= i_issue_op.src1.data;
                end
            end

            // Stores only broadcast their tag so dependents can retire
            assign result = is_store ? '0 : mem_q[addr];
        end else begin : g_ieu
            always_comb begin
                case (i_issue_op.opcode)
                    OP_ADD:  result = i_issue_op.src0.data + i_issue_op.src1.data;
                    OP_SUB:  result = i_issue_op.src0.data - i_issue_op.src1.data;
                    OP_AND:  result = i_issue_op.src0.data & i_issue_op.src1.data;
                    OP_XOR:  result = i_issue_op.src0.data ^ i_issue_op.src1.data;
                    default: result = '0;
                endcase
            end
        end
    endgenerate

    always_ff @(posedge i_clk) begin
        o_cdb.tag  <= i_issue_op.dst_tag;
        o_cdb.data <= result;
        if (i_reset) begin
            o_cdb.en <= 1'b0;
        end else begin
            o_cdb.en <= i_issue_en;
        end
    end

endmodule

`default_nettype wire

//--- src/ooo_exec_core.sv
// Out-of-order execution back end
// Dispatch switch feeding three reservation stations, each with its own
// functional unit and CDB lane

`include "ooo_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module ooo_exec_core import ooo_pkg::*; (
    input  logic   i_clk,
    input  logic   i_reset,

    input  logic   i_dispatch_en,
    input  rs_op_t i_dispatch_op,
    output logic   o_dispatch_stall,

    output cdb_t   o_cdb [0:`OOO_CDB_LANES-1]
);

    localparam lane_mask_t LSU_LANES = `OOO_LANE_IS_LSU;

    lane_mask_t rs_reserve_en;
    lane_mask_t rs_full;
    rs_op_t     rs_op;
    lane_mask_t issue_en;
    rs_op_t     issue_op [0:`OOO_CDB_LANES-1];

    rs_switch u_rs_switch (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_dispatch_en    (i_dispatch_en),
        .i_dispatch_op    (i_dispatch_op),
        .i_cdb            (o_cdb),
        .i_rs_full        (rs_full),
        .o_rs_reserve_en  (rs_reserve_en),
        .o_rs_op          (rs_op),
        .o_dispatch_stall (o_dispatch_stall)
    );

    // The load/store lane issues in order, integer lanes issue out of order
    for (genvar lane = 0; lane < `OOO_CDB_LANES; lane++) begin : g_lane
        reservation_station #(
            .P_IN_ORDER (LSU_LANES[lane])
        ) u_rs (
            .i_clk        (i_clk),
            .i_reset      (i_reset),
            .i_reserve_en (rs_reserve_en[lane]),
            .i_op         (rs_op),
            .i_cdb        (o_cdb),
            .o_full       (rs_full[lane]),
            .o_issue_en   (issue_en[lane]),
            .o_issue_op   (issue_op[lane])
        );

        exec_unit #(
            .P_FU_TYPE (LSU_LANES[lane] ? FU_LSU : FU_IEU)
        ) u_exec_unit (
            .i_clk      (i_clk),
            .i_reset    (i_reset),
            .i_issue_en (issue_en[lane]),
            .i_issue_op (issue_op[lane]),
            .o_cdb      (o_cdb[lane])
        );
    end

endmodule

`default_nettype wire

//--- bench/ooo_exec_properties.sv
// Execution back end assertions
// Bound onto the core to check reserve, stall and CDB timing rules

`include "ooo_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module ooo_exec_properties import ooo_pkg::*; (
    input wire logic       i_clk,
    input wire logic       i_reset,
    input wire lane_mask_t i_rs_reserve_en,
    input wire logic       i_dispatch_stall,
    input wire lane_mask_t i_issue_en,
    input wire cdb_t       i_cdb [0:`OOO_CDB_LANES-1]
);

    lane_mask_t cdb_en;

    always_comb begin
        for (int lane = 0; lane < `OOO_CDB_LANES; lane++) begin
            cdb_en[lane] = i_cdb[lane].en;
        end
    end

    // At most one station takes an op per cycle
    a_reserve_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0(i_rs_reserve_en))
        else $error("reserve mask is not one-hot or zero");

    a_no_enqueue_stalled: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dispatch_stall |-> (i_rs_reserve_en == '0))
        else $error("station enqueued while dispatch was stalled");

    a_cdb_quiet_after_reset: assert property (@(posedge i_clk)
        $past(i_reset) |-> (cdb_en == '0))
        else $error("CDB enable high right after reset");

    // Each unit answers exactly one cycle after its station issues
    for (genvar lane = 0; lane < `OOO_CDB_LANES; lane++) begin : g_lane
        a_issue_to_cdb: assert property (@(posedge i_clk) disable iff (i_reset)
            i_issue_en[lane] |=> cdb_en[lane])
            else $error("issue on lane %0d not followed by CDB enable", lane);
    end

endmodule

`default_nettype wire

//--- bench/ooo_exec_tb.sv
// Execution back end testbench
// Directed tests with a reference model of the ALU, memory and routing rules

`include "ooo_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module ooo_exec_tb import ooo_pkg::*; ();

    localparam int NUM_TESTS = 6;
    localparam int NTAGS     = 1 << `OOO_TAG_WIDTH;

    logic   clk;
    logic   i_reset;
    logic   i_dispatch_en;
    rs_op_t i_dispatch_op;
    logic   o_dispatch_stall;
    cdb_t   o_cdb [0:`OOO_CDB_LANES-1];

    int     errors;
    int     checks;
    int     cycle;
    int     accept_cycle;
    int     next_tag;
    bit     got_valid [0:NTAGS-1];
    data_t  got_data  [0:NTAGS-1];
    int     got_lane  [0:NTAGS-1];
    int     got_cycle [0:NTAGS-1];
    tag_t   lane_tag  [0:`OOO_CDB_LANES-1];
    data_t  mem_model [0:`OOO_MEM_WORDS-1];

    ooo_exec_core i_ooo_exec_core (
        .i_clk            (clk),
        .i_reset          (i_reset),
        .i_dispatch_en    (i_dispatch_en),
        .i_dispatch_op    (i_dispatch_op),
        .o_dispatch_stall (o_dispatch_stall),
        .o_cdb            (o_cdb)
    );

    bind ooo_exec_core ooo_exec_properties u_ooo_exec_properties (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_rs_reserve_en  (rs_reserve_en),
        .i_dispatch_stall (o_dispatch_stall),
        .i_issue_en       (issue_en),
        .i_cdb            (o_cdb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Collect every broadcast by tag, sampled away from the rising edge
    always @(negedge clk) begin
        cycle = cycle + 1;
        for (int lane = 0; lane < `OOO_CDB_LANES; lane++) begin
            if (!i_reset && o_cdb[lane].en) begin
                got_valid[o_cdb[lane].tag] = 1'b1;
                got_data[o_cdb[lane].tag]  = o_cdb[lane].data;
                got_lane[o_cdb[lane].tag]  = lane;
                got_cycle[o_cdb[lane].tag] = cycle;
                lane_tag[lane]             = o_cdb[lane].tag;
            end
        end
    end

    function automatic data_t alu_model(opcode_e op, data_t a, data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            default: return a ^ b;
        endcase
    endfunction

    function automatic rs_op_t make_op(opcode_e op, tag_t dst, logic r0, tag_t t0, data_t d0,
                                       logic r1, tag_t t1, data_t d1);
        rs_op_t o;
        o.opcode    = op;
        o.dst_tag   = dst;
        o.src0.rdy  = r0;
        o.src0.tag  = t0;
        o.src0.data = d0;
        o.src1.rdy  = r1;
        o.src1.tag  = t1;
        o.src1.data = d1;
        return o;
    endfunction

    // Tag 0 is never handed out so it can stand for an unused source
    function automatic tag_t alloc_tag();
        tag_t t;
        next_tag = (next_tag % (NTAGS - 1)) + 1;
        t = tag_t'(next_tag);
        got_valid[t] = 1'b0;
        return t;
    endfunction

    task automatic check_data(string what, data_t got, data_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR at %0t: %s data %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(string what, tag_t got, tag_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR at %0t: %s tag %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic dispatch(rs_op_t op);
        bit stalled;
        @(posedge clk);
        i_dispatch_en <= 1'b1;
        i_dispatch_op <= op;
        stalled = 1'b1;
        while (stalled) begin
            @(negedge clk);
            stalled = o_dispatch_stall;
            @(posedge clk);
        end
        accept_cycle = cycle;
        i_dispatch_en <= 1'b0;
    endtask

    task automatic wait_result(tag_t t, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 200 && !ok; n++) begin
            @(posedge clk);
            ok = got_valid[t];
        end
        if (!ok) begin
            $display("Timed out waiting for the result of tag %0d", t);
            errors++;
        end
    endtask

    task automatic expect_result(string what, tag_t t, data_t exp);
        bit ok;
        wait_result(t, ok);
        if (ok) begin
            check_data(what, got_data[t], exp);
        end
    endtask

    task automatic report(string name, int err_before);
        $display("%s: %s", name, (errors == err_before) ? "pass" : "FAIL");
    endtask

    task automatic test_alu_random();
        int    e0;
        tag_t  t;
        data_t a;
        data_t b;
        opcode_e op;
        bit    ok;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            op = opcode_e'($urandom_range(3, 0));
            a  = $urandom();
            b  = $urandom();
            t  = alloc_tag();
            dispatch(make_op(op, t, 1'b1, '0, a, 1'b1, '0, b));
            wait_result(t, ok);
            if (ok) begin
                check_data("alu", got_data[t], alu_model(op, a, b));
                // Result is on the CDB two edges after the dispatch edge
                if (got_cycle[t] - accept_cycle != 3) begin
                    $display("Result of tag %0d arrived with the wrong latency", t);
                    errors++;
                end
            end
        end
        report("alu_random", e0);
    endtask

    task automatic test_bypass();
        int   e0;
        tag_t tp;
        tag_t tc;
        e0 = errors;
        tp = alloc_tag();
        tc = alloc_tag();
        dispatch(make_op(OP_ADD, tp, 1'b1, '0, 32'h100, 1'b1, '0, 32'h23));
        @(posedge clk);
        // Taken at the edge that ends the producer's CDB cycle
        dispatch(make_op(OP_SUB, tc, 1'b0, tp, '0, 1'b1, '0, 32'h3));
        expect_result("bypass producer", tp, 32'h123);
        expect_result("bypass consumer", tc, 32'h120);
        report("dispatch_bypass", e0);
    endtask

    task automatic test_wakeup_chain();
        int    e0;
        tag_t  t [0:3];
        data_t v [0:3];
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            t[i] = alloc_tag();
        end
        v[0] = $urandom();
        v[1] = v[0] + 32'd5;
        v[2] = v[1] ^ v[0];
        v[3] = v[2] - v[1];
        dispatch(make_op(OP_ADD, t[0], 1'b1, '0, v[0], 1'b1, '0, '0));
        dispatch(make_op(OP_ADD, t[1], 1'b0, t[0], '0, 1'b1, '0, 32'd5));
        // The first producer has already broadcast, so its value arrives ready
        dispatch(make_op(OP_XOR, t[2], 1'b0, t[1], '0, 1'b1, '0, v[0]));
        dispatch(make_op(OP_SUB, t[3], 1'b0, t[2], '0, 1'b0, t[1], '0));
        for (int i = 0; i < 4; i++) begin
            expect_result("chain", t[i], v[i]);
        end
        report("wakeup_chain", e0);
    endtask

    task automatic test_routing();
        int    e0;
        int    exp_lane;
        tag_t  t;
        data_t d;
        bit    ok;
        e0 = errors;
        exp_lane = -1;
        for (int i = 0; i < 6; i++) begin
            t = alloc_tag();
            dispatch(make_op(OP_AND, t, 1'b1, '0, 32'hffff, 1'b1, '0, 32'(i)));
            wait_result(t, ok);
            if (ok) begin
                if (exp_lane < 0) begin
                    // The first op only sets the phase of the alternation
                    exp_lane = got_lane[t];
                    if (exp_lane > 1) begin
                        $display("Integer op with tag %0d appeared on the load/store lane", t);
                        errors++;
                    end
                end else begin
                    check_tag("ieu lane", lane_tag[exp_lane], t);
                end
                exp_lane = 1 - exp_lane;
            end
        end
        for (int i = 0; i < 4; i++) begin
            t = alloc_tag();
            d = $urandom();
            mem_model[i] = d;
            dispatch(make_op(OP_STORE, t, 1'b1, '0, 32'(i), 1'b1, '0, d));
            wait_result(t, ok);
            if (ok) begin
                check_tag("store lane", lane_tag[2], t);
            end
            t = alloc_tag();
            dispatch(make_op(OP_LOAD, t, 1'b1, '0, 32'(i), 1'b1, '0, '0));
            wait_result(t, ok);
            if (ok) begin
                check_tag("load lane", lane_tag[2], t);
                check_data("routing load", got_data[t], mem_model[i]);
            end
        end
        report("routing", e0);
    endtask

    task automatic test_store_load();
        int     e0;
        tag_t   ts;
        tag_t   tl;
        data_t  d;
        logic [3:0] addr;
        e0 = errors;
        addr = 4'($urandom());
        d    = $urandom();
        ts   = alloc_tag();
        tl   = alloc_tag();
        mem_model[addr] = d;
        dispatch(make_op(OP_STORE, ts, 1'b1, '0, 32'(addr), 1'b1, '0, d));
        dispatch(make_op(OP_LOAD, tl, 1'b1, '0, 32'(addr), 1'b1, '0, '0));
        expect_result("store", ts, '0);
        expect_result("load after store", tl, mem_model[addr]);
        report("store_load", e0);
    endtask

    task automatic test_stall_drain();
        int    e0;
        tag_t  ts;
        tag_t  tp;
        tag_t  tl [0:4];
        data_t d;
        bit    saw_stall;
        e0 = errors;
        d  = $urandom();
        ts = alloc_tag();
        mem_model[7] = d;
        dispatch(make_op(OP_STORE, ts, 1'b1, '0, 32'd7, 1'b1, '0, d));
        expect_result("stall store", ts, '0);
        tp = alloc_tag();
        for (int i = 0; i < 5; i++) begin
            tl[i] = alloc_tag();
        end
        // Loads whose address waits on a producer that is not dispatched yet
        for (int i = 0; i < 4; i++) begin
            dispatch(make_op(OP_LOAD, tl[i], 1'b0, tp, '0, 1'b1, '0, '0));
        end
        @(posedge clk);
        i_dispatch_en <= 1'b1;
        i_dispatch_op <= make_op(OP_LOAD, tl[4], 1'b1, '0, 32'd7, 1'b1, '0, '0);
        saw_stall = 1'b1;
        repeat (3) begin
            @(negedge clk);
            saw_stall = saw_stall & o_dispatch_stall;
        end
        @(posedge clk);
        i_dispatch_en <= 1'b0;
        if (!saw_stall) begin
            $display("Dispatch stall did not stay high with the load/store station full");
            errors++;
        end
        dispatch(make_op(OP_ADD, tp, 1'b1, '0, 32'd7, 1'b1, '0, '0));
        dispatch(make_op(OP_LOAD, tl[4], 1'b1, '0, 32'd7, 1'b1, '0, '0));
        expect_result("stall producer", tp, 32'd7);
        for (int i = 0; i < 5; i++) begin
            expect_result("drained load", tl[i], mem_model[7]);
        end
        report("stall_drain", e0);
    endtask

    initial begin
        #(NUM_TESTS * 2000);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h0655_cd01));
        errors        = 0;
        checks        = 0;
        cycle         = 0;
        next_tag      = 0;
        i_reset       = 1'b1;
        i_dispatch_en = 1'b0;
        i_dispatch_op = '0;
        for (int i = 0; i < NTAGS; i++) begin
            got_valid[i] = 1'b0;
        end
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;
        @(posedge clk);
        test_alu_random();
        test_bypass();
        test_wakeup_chain();
        test_routing();
        test_store_load();
        test_stall_drain();
        $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+src
src/ooo_pkg.sv
src/rr_picker.sv
src/rs_switch.sv
src/reservation_station.sv
src/exec_unit.sv
src/ooo_exec_core.sv
bench/ooo_exec_properties.sv
bench/ooo_exec_tb.sv
